//--- sim.f
+incdir+.
axi4s_pkg.sv
sync_fifo.sv
axi4s_ingress.sv
axi4s_egress.sv
stream_buf_top.sv
stream_buf_checker.sv
tb_stream_buf.sv

//--- Bender.yml
package:
  name: stream_buf

sources:
  - include_dirs:
      - .
    files:
      - axi4s_pkg.sv
      - sync_fifo.sv
      - axi4s_ingress.sv
      - axi4s_egress.sv
      - stream_buf_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - stream_buf_checker.sv
      - tb_stream_buf.sv

//--- tb_stream_buf.sv
// stream buffer testbench
`timescale 1ns/1ps
`include "stream_buf_macros.svh"

module tb_stream_buf;

  import axi4s_pkg::*;

  localparam int n_rows         = 26;
  localparam int stall_hold     = 6;   // cycles kept stalled after in_tready drops
  localparam int timeout_cycles = n_rows * 40 + 200;

  logic                       clk = 1'b0;
  logic                       rst_n;
  logic                       in_tvalid;
  logic [`AXI4S_DATA_W-1:0]   in_tdata;
  logic [`AXI4S_DATA_W/8-1:0] in_tkeep;
  axi4s_user_t                in_tuser;
  logic                       in_tlast;
  logic                       in_tready;
  logic                       out_tvalid;
  logic [`AXI4S_DATA_W-1:0]   out_tdata;
  logic [`AXI4S_DATA_W/8-1:0] out_tkeep;
  axi4s_user_t                out_tuser;
  logic                       out_tlast;
  logic                       out_tready;
  logic                       buf_aempty;

  axi4s_beat_t rows [n_rows];      // stimulus in expected output order
  logic        stall_at [n_rows];  // stall downstream when this row comes up
  int          n_loaded = 0;
  int          row_ptr = 0;
  int          stall_row = -1;
  int          low_cycles = 0;
  int          cycles = 0;
  int          error_count;
  int          in_count;
  int          out_count;
  logic        started = 1'b0;
  logic        stall_on = 1'b0;
  logic        ready_seen = 1'b0;
  logic        final_check = 1'b0;
  logic [31:0] lfsr = 32'h1a97;

  always #4 clk = ~clk;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic add_row(input logic [63:0] data, input logic [7:0] keep,
                         input logic [3:0] user, input logic last, input logic stall);
    rows[n_loaded]     = {data, keep, user, last};
    stall_at[n_loaded] = stall;
    n_loaded           = n_loaded + 1;
  endtask

  stream_buf_top stream_buf_top_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_tvalid  (in_tvalid),
    .in_tdata   (in_tdata),
    .in_tkeep   (in_tkeep),
    .in_tuser   (in_tuser),
    .in_tlast   (in_tlast),
    .in_tready  (in_tready),
    .out_tvalid (out_tvalid),
    .out_tdata  (out_tdata),
    .out_tkeep  (out_tkeep),
    .out_tuser  (out_tuser),
    .out_tlast  (out_tlast),
    .out_tready (out_tready),
    .buf_aempty (buf_aempty)
  );

  stream_buf_checker stream_buf_checker_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_tvalid   (in_tvalid),
    .in_tready   (in_tready),
    .in_tdata    (in_tdata),
    .in_tkeep    (in_tkeep),
    .in_tuser    (in_tuser),
    .in_tlast    (in_tlast),
    .out_tvalid  (out_tvalid),
    .out_tready  (out_tready),
    .out_tdata   (out_tdata),
    .out_tkeep   (out_tkeep),
    .out_tuser   (out_tuser),
    .out_tlast   (out_tlast),
    .buf_aempty  (buf_aempty),
    .stall       (stall_on),
    .final_check (final_check),
    .error_count (error_count),
    .in_count    (in_count),
    .out_count   (out_count)
  );

  // all dut inputs change on the falling edge
  always @(negedge clk)
  begin
    if (started)
    begin
      if (in_tvalid && ready_seen)
        row_ptr = row_ptr + 1;  // beat went in at the last rising edge
      if (row_ptr < n_rows && stall_at[row_ptr] && row_ptr != stall_row)
      begin
        stall_row  = row_ptr;
        stall_on   = 1'b1;
        low_cycles = 0;
      end
      if (stall_on && !in_tready)
        low_cycles = low_cycles + 1;
      if (stall_on && low_cycles > stall_hold)
        stall_on = 1'b0;
      if (row_ptr < n_rows)
      begin
        in_tvalid = 1'b1;
        {in_tdata, in_tkeep, in_tuser, in_tlast} = rows[row_ptr];
      end
      else
        in_tvalid = 1'b0;
      if (stall_on)
        out_tready = 1'b0;
      else if (row_ptr >= n_rows)
        out_tready = 1'b1;  // drain
      else
      begin
        lfsr       = lfsr_next(lfsr);
        out_tready = lfsr[0];
      end
      ready_seen = in_tready;
    end
  end

  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (cycles >= timeout_cycles)
    begin
      $display("timeout after %0d cycles, %0d of %0d beats delivered",
               cycles, out_count, n_rows);
      $display("Checks failed");
      $finish;
    end
  end

  initial
  begin
    rst_n      = 1'b0;
    in_tvalid  = 1'b0;
    in_tdata   = '0;
    in_tkeep   = '0;
    in_tuser   = '0;
    in_tlast   = 1'b0;
    out_tready = 1'b0;
    add_row(64'h0123_4567_89ab_cdef, 8'hff, 4'h1, 1'b0, 1'b0);
    add_row(64'hfedc_ba98_7654_3210, 8'hff, 4'h2, 1'b0, 1'b0);
    add_row(64'h0000_0000_0000_0001, 8'hff, 4'h3, 1'b0, 1'b0);
    add_row(64'h8000_0000_0000_0000, 8'h0f, 4'h4, 1'b1, 1'b0);
    add_row(64'h1111_2222_3333_4444, 8'hff, 4'h5, 1'b0, 1'b1);  // long stall starts here
    add_row(64'h5555_6666_7777_8888, 8'hff, 4'h6, 1'b0, 1'b0);
    add_row(64'h9999_aaaa_bbbb_cccc, 8'hff, 4'h7, 1'b0, 1'b0);
    add_row(64'hdddd_eeee_ffff_0000, 8'h01, 4'h8, 1'b1, 1'b0);
    add_row(64'h0f0f_0f0f_0f0f_0f0f, 8'hff, 4'h9, 1'b0, 1'b0);
    add_row(64'hf0f0_f0f0_f0f0_f0f0, 8'hff, 4'ha, 1'b0, 1'b0);
    add_row(64'haaaa_5555_aaaa_5555, 8'hff, 4'hb, 1'b0, 1'b0);
    add_row(64'h5555_aaaa_5555_aaaa, 8'h3f, 4'hc, 1'b1, 1'b0);
    add_row(64'hdead_beef_cafe_f00d, 8'hff, 4'hd, 1'b0, 1'b0);
    add_row(64'h1357_9bdf_2468_ace0, 8'hff, 4'he, 1'b0, 1'b0);
    add_row(64'h0000_ffff_0000_ffff, 8'hff, 4'hf, 1'b0, 1'b0);
    add_row(64'hffff_0000_ffff_0000, 8'h7f, 4'h0, 1'b1, 1'b0);
    add_row(64'h0101_0202_0303_0404, 8'hff, 4'h1, 1'b0, 1'b0);
    add_row(64'h0505_0606_0707_0808, 8'hff, 4'h2, 1'b0, 1'b0);
    add_row(64'h0909_0a0a_0b0b_0c0c, 8'hff, 4'h3, 1'b0, 1'b0);
    add_row(64'h0d0d_0e0e_0f0f_1010, 8'h03, 4'h4, 1'b1, 1'b0);
    add_row(64'h7fff_ffff_ffff_fffe, 8'hff, 4'h5, 1'b0, 1'b0);
    add_row(64'h3c3c_c3c3_3c3c_c3c3, 8'hff, 4'h6, 1'b0, 1'b0);
    add_row(64'h2468_1357_2468_1357, 8'hff, 4'h7, 1'b0, 1'b0);
    add_row(64'h0bad_f00d_0bad_f00d, 8'h1f, 4'h8, 1'b1, 1'b0);
    add_row(64'h6666_7777_8888_9999, 8'hff, 4'h9, 1'b0, 1'b0);
    add_row(64'h0000_0000_0000_0000, 8'h80, 4'hf, 1'b1, 1'b0);  // single byte last beat
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(posedge clk);
    started = 1'b1;
    wait (out_count == n_rows);
    repeat (4) @(negedge clk);
    final_check = 1'b1;
    @(negedge clk);
    final_check = 1'b0;
    @(negedge clk);
    $display("errors: %0d, beats in: %0d, beats out: %0d", error_count, in_count, out_count);
    if (error_count == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

//--- stream_buf_checker.sv
// stream buffer scoreboard
`timescale 1ns/1ps
`include "stream_buf_macros.svh"

module stream_buf_checker (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       in_tvalid,
  input  logic                       in_tready,
  input  logic [`AXI4S_DATA_W-1:0]   in_tdata,
  input  logic [`AXI4S_DATA_W/8-1:0] in_tkeep,
  input  axi4s_pkg::axi4s_user_t     in_tuser,
  input  logic                       in_tlast,
  input  logic                       out_tvalid,
  input  logic                       out_tready,
  input  logic [`AXI4S_DATA_W-1:0]   out_tdata,
  input  logic [`AXI4S_DATA_W/8-1:0] out_tkeep,
  input  axi4s_pkg::axi4s_user_t     out_tuser,
  input  logic                       out_tlast,
  input  logic                       buf_aempty,
  input  logic                       stall,        // downstream held off by the testbench
  input  logic                       final_check,  // one cycle once everything drained
  output int                         error_count,
  output int                         in_count,
  output int                         out_count
);

  import axi4s_pkg::*;

  axi4s_beat_t pending[$];  // accepted but not yet delivered
  axi4s_beat_t in_beat;
  axi4s_beat_t out_beat;
  axi4s_beat_t held_beat;   // beat waiting on out_tready
  axi4s_beat_t exp_beat;
  logic        held;
  logic        check_reset;

  task automatic report_mismatch(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
    $display("FAILED %s expected %h actual %h at %0t", name, expected, actual, $time);
    error_count = error_count + 1;
  endtask

  task automatic report_problem(input string msg);
    $display("%s at %0t", msg, $time);
    error_count = error_count + 1;
  endtask

  task automatic compare_beat(input string tag, input axi4s_beat_t expected,
                              input axi4s_beat_t actual);
    if (actual.tdata !== expected.tdata)
      report_mismatch({tag, "out_tdata"}, expected.tdata, actual.tdata);
    if (actual.tkeep !== expected.tkeep)
      report_mismatch({tag, "out_tkeep"}, expected.tkeep, actual.tkeep);
    if (actual.tuser !== expected.tuser)
      report_mismatch({tag, "out_tuser"}, expected.tuser, actual.tuser);
    if (actual.tlast !== expected.tlast)
      report_mismatch({tag, "out_tlast"}, expected.tlast, actual.tlast);
  endtask

  always @(posedge clk)
  begin
    in_beat  = {in_tdata, in_tkeep, in_tuser, in_tlast};
    out_beat = {out_tdata, out_tkeep, out_tuser, out_tlast};
    if (!rst_n)
    begin
      error_count = 0;
      in_count    = 0;
      out_count   = 0;
      pending.delete();
      held        = 1'b0;
      check_reset = 1'b1;
    end
    else
    begin
      if (check_reset)  // first edge out of reset
      begin
        if (in_tready !== 1'b1)
          report_mismatch("in_tready", 1, in_tready);
        if (out_tvalid !== 1'b0)
          report_mismatch("out_tvalid", 0, out_tvalid);
        if (buf_aempty !== 1'b1)
          report_mismatch("buf_aempty", 1, buf_aempty);
        check_reset = 1'b0;
      end
      if (held)
      begin
        if (out_tvalid !== 1'b1)
          report_problem("out_tvalid fell while a beat was still waiting");
        compare_beat("held ", held_beat, out_beat);
      end
      if (in_tvalid && in_tready)
      begin
        pending.push_back(in_beat);
        in_count = in_count + 1;
      end
      if (out_tvalid && out_tready)
      begin
        if (pending.size() == 0)
          report_problem("output beat delivered with no accepted input beat left");
        else
        begin
          exp_beat = pending.pop_front();
          compare_beat("", exp_beat, out_beat);
        end
        out_count = out_count + 1;
      end
      if (in_count - out_count > `BUF_DEPTH + 1)
        report_problem($sformatf("%0d beats held inside the buffer, above depth plus one",
                                 in_count - out_count));
      if (stall && !in_tready && buf_aempty !== 1'b0)
        report_mismatch("buf_aempty", 0, buf_aempty);  // fifo is near full here
      if (final_check)
      begin
        if (pending.size() != 0)
          report_problem($sformatf("%0d accepted beats never came out", pending.size()));
        if (buf_aempty !== 1'b1)
          report_mismatch("buf_aempty", 1, buf_aempty);
        if (out_tvalid !== 1'b0)
          report_mismatch("out_tvalid", 0, out_tvalid);
      end
      held      = out_tvalid && !out_tready;
      held_beat = out_beat;
    end
  end

endmodule

//--- stream_buf_top.sv
// axi4-stream buffer slice top
`timescale 1ns/1ps
`include "stream_buf_macros.svh"

module stream_buf_top (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       in_tvalid,
  input  logic [`AXI4S_DATA_W-1:0]   in_tdata,
  input  logic [`AXI4S_DATA_W/8-1:0] in_tkeep,
  input  axi4s_pkg::axi4s_user_t     in_tuser,
  input  logic                       in_tlast,
  output logic                       in_tready,
  output logic                       out_tvalid,
  output logic [`AXI4S_DATA_W-1:0]   out_tdata,
  output logic [`AXI4S_DATA_W/8-1:0] out_tkeep,
  output axi4s_pkg::axi4s_user_t     out_tuser,
  output logic                       out_tlast,
  input  logic                       out_tready,
  output logic                       buf_aempty
);

  import axi4s_pkg::*;

  axi4s_beat_t buf_out;    // fifo head
  logic        buf_empty;
  logic        buf_rd;

  axi4s_ingress axi4s_ingress_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_tvalid  (in_tvalid),
    .in_tdata   (in_tdata),
    .in_tkeep   (in_tkeep),
    .in_tuser   (in_tuser),
    .in_tlast   (in_tlast),
    .in_tready  (in_tready),
    .buf_rd     (buf_rd),
    .buf_out    (buf_out),
    .buf_empty  (buf_empty),
    .buf_aempty (buf_aempty)  // status out
  );

  axi4s_egress axi4s_egress_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .buf_out    (buf_out),
    .buf_empty  (buf_empty),
    .buf_rd     (buf_rd),
    .out_tvalid (out_tvalid),
    .out_tdata  (out_tdata),
    .out_tkeep  (out_tkeep),
    .out_tuser  (out_tuser),
    .out_tlast  (out_tlast),
    .out_tready (out_tready)
  );

endmodule

//--- axi4s_egress.sv
// axi4-stream egress slice
`timescale 1ns/1ps
`include "stream_buf_macros.svh"

module axi4s_egress (
  input  logic                             clk,
  input  logic                             rst_n,
  input  axi4s_pkg::axi4s_beat_t           buf_out,
  input  logic                             buf_empty,
  output logic                             buf_rd,
  output logic                             out_tvalid,
  output logic [`AXI4S_DATA_W-1:0]         out_tdata,
  output logic [`AXI4S_DATA_W/8-1:0]       out_tkeep,
  output axi4s_pkg::axi4s_user_t           out_tuser,
  output logic                             out_tlast,
  input  logic                             out_tready
);

  // pop when the head is valid and the output slot is free or draining
  assign buf_rd = ~buf_empty & (~out_tvalid | out_tready);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      out_tvalid <= 1'b0;
    else if (buf_rd)
      out_tvalid <= 1'b1;  // refill back to back
    else if (out_tready)
      out_tvalid <= 1'b0;  // last beat went out
  end

  // beat only moves on a pop so it holds while stalled
  always_ff @(posedge clk)
  begin
    if (buf_rd)
    begin
      out_tdata <= buf_out.tdata;
      out_tkeep <= buf_out.tkeep;
      out_tuser <= buf_out.tuser;
      out_tlast <= buf_out.tlast;
    end
  end

endmodule

//--- axi4s_ingress.sv
// axi4-stream ingress slice
`timescale 1ns/1ps
`include "stream_buf_macros.svh"

module axi4s_ingress (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       in_tvalid,
  input  logic [`AXI4S_DATA_W-1:0]   in_tdata,
  input  logic [`AXI4S_DATA_W/8-1:0] in_tkeep,
  input  axi4s_pkg::axi4s_user_t     in_tuser,
  input  logic                       in_tlast,
  output logic                       in_tready,
  input  logic                       buf_rd,
  output axi4s_pkg::axi4s_beat_t     buf_out,
  output logic                       buf_empty,
  output logic                       buf_aempty
);

  import axi4s_pkg::*;

  axi4s_beat_t in_beat;    // loose fields packed
  axi4s_beat_t wr_beat;    // registered beat toward fifo
  logic        wr_en;      // one cycle per accepted beat
  logic        buf_afull;

  assign in_beat   = '{tdata: in_tdata, tkeep: in_tkeep, tuser: in_tuser, tlast: in_tlast};
  assign in_tready = ~buf_afull;  // margin of 1 covers the beat in wr_beat

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      wr_en <= 1'b0;
    else
      wr_en <= in_tvalid & in_tready;
  end

  always_ff @(posedge clk)
  begin
    if (in_tvalid & in_tready)
      wr_beat <= in_beat;
  end

  sync_fifo #(
    .payload_t  (axi4s_beat_t),
    .depth      (`BUF_DEPTH),
    .afull_val  (`BUF_AFULL_VAL),
    .aempty_val (`BUF_AEMPTY_VAL)
  ) sync_fifo_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .wen    (wr_en),
    .wdata  (wr_beat),
    .ren    (buf_rd),      // plain read strobe from the consumer
    .rdata  (buf_out),
    .empty  (buf_empty),
    .aempty (buf_aempty),
    .afull  (buf_afull)
  );

endmodule

//--- sync_fifo.sv
// show-ahead synchronous fifo
`timescale 1ns/1ps
`include "stream_buf_macros.svh"

module sync_fifo #(
  parameter type payload_t  = logic [7:0],
  parameter int  depth      = `BUF_DEPTH,
  parameter int  afull_val  = `BUF_AFULL_VAL,
  parameter int  aempty_val = `BUF_AEMPTY_VAL
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     wen,
  input  payload_t wdata,
  input  logic     ren,
  output payload_t rdata,
  output logic     empty,
  output logic     aempty,
  output logic     afull
);

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);

  payload_t         mem [depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;
  logic [cnt_w-1:0] count_nxt;
  logic             do_wr;
  logic             do_rd;

  assign do_wr = wen & (count != cnt_w'(depth));  // never write past the last slot
  assign do_rd = ren & ~empty;
  assign rdata = mem[rd_ptr];                     // head entry while not empty

  always_comb
  begin
    case ({do_wr, do_rd})
      2'b10:   count_nxt = count + 1'b1;
      2'b01:   count_nxt = count - 1'b1;
      default: count_nxt = count;  // idle or simultaneous push/pop
    endcase
  end

  // payload storage
  always_ff @(posedge clk)
  begin
    if (do_wr)
      mem[wr_ptr] <= wdata;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end
    else
    begin
      if (do_wr)
        wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_rd)
        rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
    end
  end

  // flags are registered from the next count so they track count exactly
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      count  <= '0;
      empty  <= 1'b1;
      aempty <= 1'b1;
      afull  <= 1'b0;
    end
    else
    begin
      count  <= count_nxt;
      empty  <= (count_nxt == '0);
      aempty <= (count_nxt <= cnt_w'(aempty_val));
      afull  <= (count_nxt >= cnt_w'(depth - afull_val));
    end
  end

endmodule

//--- axi4s_pkg.sv
// axi4-stream beat types
`include "stream_buf_macros.svh"

package axi4s_pkg;

  // sideband user bits carried with every beat
  typedef logic [3:0] axi4s_user_t;

  // one stream beat as it sits in the fifo
  typedef struct packed {
    logic [`AXI4S_DATA_W-1:0]   tdata;
    logic [`AXI4S_DATA_W/8-1:0] tkeep;  // byte enables
    axi4s_user_t                tuser;
    logic                       tlast;  // end of packet
  } axi4s_beat_t;

endpackage

//--- stream_buf_macros.svh
// stream buffer parameters
`ifndef STREAM_BUF_MACROS_SVH
`define STREAM_BUF_MACROS_SVH

// datapath width in bits
`define AXI4S_DATA_W   64

// fifo sizing
`define BUF_DEPTH      16  // entries
`define BUF_AFULL_VAL  1   // afull when count >= depth - val
`define BUF_AEMPTY_VAL 1   // aempty when count <= val

`endif
